// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_cuckoo_hash
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^Test OK$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
logic/cuckoo_pkg.sv
logic/hash_index_unit.sv
logic/bucket_store.sv
logic/overflow_stash.sv
logic/placement_ctrl.sv
logic/response_builder.sv
logic/cuckoo_hash_top.sv
test/tb_checker.sv
test/tb_cuckoo_hash.sv

// File: logic/bucket_store.sv
`timescale 1ns/1ps
`default_nettype none

module bucket_store import cuckoo_pkg::*; #(
    parameter int BUCKET_SIZE = 2,
    parameter int INDEX_WIDTH = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         clk_en_i,
    input  logic [INDEX_WIDTH-1:0]       index_i,
    output entry_t [BUCKET_SIZE-1:0]     row_o,
    input  logic [BUCKET_SIZE-1:0]       slot_i,  // one-hot bucket select
    input  logic                         write_i,
    input  logic                         clear_i,
    input  entry_t                       entry_i
);

    localparam int ROWS = 1 << INDEX_WIDTH;

    logic [BUCKET_SIZE-1:0] valid_q [ROWS];
    logic [KEY_WIDTH-1:0]   key_q   [ROWS][BUCKET_SIZE];
    logic [DATA_WIDTH-1:0]  data_q  [ROWS][BUCKET_SIZE];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < ROWS; r++) begin
                valid_q[r] <= '0;
            end
        end else if (clk_en_i) begin
            if (write_i) begin
                valid_q[index_i] <= valid_q[index_i] | slot_i;
            end else if (clear_i) begin
                valid_q[index_i] <= valid_q[index_i] & ~slot_i; // key and data stay, slot just frees up
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en_i && write_i) begin
            for (int b = 0; b < BUCKET_SIZE; b++) begin
                if (slot_i[b]) begin
                    key_q[index_i][b]  <= entry_i.key;
                    data_q[index_i][b] <= entry_i.data;
                end
            end
        end
    end

    // the row is visible in the same cycle as its index
    for (genvar b = 0; b < BUCKET_SIZE; b++) begin : g_row
        assign row_o[b].valid = valid_q[index_i][b];
        assign row_o[b].key   = key_q[index_i][b];
        assign row_o[b].data  = data_q[index_i][b];
    end

    // placement never asks one table to fill and free a slot in the same request
    a_write_clear_excl: assert property (
        @(posedge clk) disable iff (reset) !(write_i && clear_i)
    ) else $error("bucket_store: write and clear asserted together");

endmodule

`default_nettype wire

// File: logic/cuckoo_hash_top.sv
`timescale 1ns/1ps
`default_nettype none

module cuckoo_hash_top import cuckoo_pkg::*; #(
    parameter int NUM_TABLES  = 3,
    parameter int BUCKET_SIZE = 2,
    parameter int INDEX_WIDTH = 2,
    parameter int STASH_SIZE  = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_en_i,
    input  hash_req_t req_i,
    output hash_rsp_t rsp_o
);

    logic [NUM_TABLES-1:0][INDEX_WIDTH-1:0] index;
    entry_t [NUM_TABLES-1:0][BUCKET_SIZE-1:0] rows;
    logic [NUM_TABLES-1:0][BUCKET_SIZE-1:0] match;
    logic [NUM_TABLES-1:0][BUCKET_SIZE-1:0] slot;
    logic [NUM_TABLES-1:0]                  table_write;
    logic [NUM_TABLES-1:0]                  table_clear;
    entry_t                                 new_entry;
    logic                                   stash_hit;
    logic [DATA_WIDTH-1:0]                  stash_data;
    logic                                   stash_full;
    logic                                   stash_insert;
    logic                                   stash_remove;
    outcome_t                               outcome;

    hash_index_unit #(
        .NUM_TABLES (NUM_TABLES),
        .INDEX_WIDTH(INDEX_WIDTH)
    ) i_index (
        .key_i  (req_i.key),
        .index_o(index)
    );

    for (genvar t = 0; t < NUM_TABLES; t++) begin : g_table
        bucket_store #(
            .BUCKET_SIZE(BUCKET_SIZE),
            .INDEX_WIDTH(INDEX_WIDTH)
        ) i_table (
            .clk     (clk),
            .reset   (reset),
            .clk_en_i(clk_en_i),
            .index_i (index[t]),
            .row_o   (rows[t]),
            .slot_i  (slot[t]),
            .write_i (table_write[t]),
            .clear_i (table_clear[t]),
            .entry_i (new_entry)
        );
    end

    overflow_stash #(
        .STASH_SIZE(STASH_SIZE)
    ) i_stash (
        .clk       (clk),
        .reset     (reset),
        .clk_en_i  (clk_en_i),
        .key_i     (req_i.key),
        .data_i    (req_i.data),
        .insert_i  (stash_insert),
        .remove_i  (stash_remove),
        .hit_o     (stash_hit),
        .hit_data_o(stash_data),
        .full_o    (stash_full)
    );

    placement_ctrl #(
        .NUM_TABLES (NUM_TABLES),
        .BUCKET_SIZE(BUCKET_SIZE)
    ) i_place (
        .req_i         (req_i),
        .clk_en_i      (clk_en_i),
        .rows_i        (rows),
        .stash_hit_i   (stash_hit),
        .stash_full_i  (stash_full),
        .match_o       (match),
        .slot_o        (slot),
        .write_o       (table_write),
        .clear_o       (table_clear),
        .entry_o       (new_entry),
        .stash_insert_o(stash_insert),
        .stash_remove_o(stash_remove),
        .outcome_o     (outcome)
    );

    response_builder #(
        .NUM_TABLES (NUM_TABLES),
        .BUCKET_SIZE(BUCKET_SIZE)
    ) i_rsp (
        .clk         (clk),
        .reset       (reset),
        .clk_en_i    (clk_en_i),
        .outcome_i   (outcome),
        .match_i     (match),
        .rows_i      (rows),
        .stash_data_i(stash_data),
        .rsp_o       (rsp_o)
    );

endmodule

`default_nettype wire

// File: logic/cuckoo_pkg.sv
`default_nettype none

package cuckoo_pkg;

    // widths of the stored pair, fixed here because the structs carry them
    localparam int KEY_WIDTH  = 16;
    localparam int DATA_WIDTH = 32;

    // the salt table limits how many tables a build may have
    localparam int MAX_TABLES = 4;

    // table t folds key ^ TABLE_SALT[t], entry 0 sits in the low bits
    localparam logic [MAX_TABLES-1:0][KEY_WIDTH-1:0] TABLE_SALT = '{
        16'h1f6b,
        16'h9e37,
        16'hc3a5,
        16'h5a3c
    };

    typedef enum logic [1:0] {
        OP_NOP    = 2'b00,
        OP_READ   = 2'b01,
        OP_WRITE  = 2'b10,
        OP_DELETE = 2'b11
    } op_e;

    typedef struct packed {
        logic                  valid;
        logic [KEY_WIDTH-1:0]  key;
        logic [DATA_WIDTH-1:0] data;
    } entry_t;

    typedef struct packed {
        op_e                   op;
        logic [KEY_WIDTH-1:0]  key;
        logic [DATA_WIDTH-1:0] data; // only meaningful for a write
    } hash_req_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] read_data;
        logic                  no_deletion_target;
        logic                  no_write_space;
        logic                  no_element_found;
        logic                  key_already_present;
    } hash_rsp_t;

    // what the placement logic decided for the current request
    typedef struct packed {
        op_e  op;
        logic key_found;  // hit in some table or in the stash
        logic placed;     // a write went into a table or the stash
        logic from_stash; // the hit came from the stash
    } outcome_t;

endpackage

`default_nettype wire

// File: logic/hash_index_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hash_index_unit import cuckoo_pkg::*; #(
    parameter int NUM_TABLES  = 3,
    parameter int INDEX_WIDTH = 2
) (
    input  logic [KEY_WIDTH-1:0]                    key_i,
    output logic [NUM_TABLES-1:0][INDEX_WIDTH-1:0] index_o
);

    // number of INDEX_WIDTH slices needed to cover the key
    localparam int NUM_SLICES = (KEY_WIDTH + INDEX_WIDTH - 1) / INDEX_WIDTH;
    localparam int PAD_WIDTH  = NUM_SLICES * INDEX_WIDTH;

    for (genvar t = 0; t < NUM_TABLES; t++) begin : g_table
        logic [PAD_WIDTH-1:0]   salted;
        logic [INDEX_WIDTH-1:0] fold;

        always_comb begin
            salted = '0; // top slice is zero padded when the key does not divide evenly
            salted[KEY_WIDTH-1:0] = key_i ^ TABLE_SALT[t];
            fold = '0;
            for (int s = 0; s < NUM_SLICES; s++) begin
                fold = fold ^ salted[s*INDEX_WIDTH +: INDEX_WIDTH];
            end
        end

        assign index_o[t] = fold;
    end

endmodule

`default_nettype wire

// File: logic/overflow_stash.sv
`timescale 1ns/1ps
`default_nettype none

module overflow_stash import cuckoo_pkg::*; #(
    parameter int STASH_SIZE = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_en_i,
    input  logic [KEY_WIDTH-1:0]  key_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    input  logic                  insert_i,
    input  logic                  remove_i,
    output logic                  hit_o,
    output logic [DATA_WIDTH-1:0] hit_data_o,
    output logic                  full_o
);

    localparam int CNT_WIDTH = $clog2(STASH_SIZE + 1);

    logic [STASH_SIZE-1:0] valid_q;
    logic [KEY_WIDTH-1:0]  key_q  [STASH_SIZE];
    logic [DATA_WIDTH-1:0] data_q [STASH_SIZE];
    logic [CNT_WIDTH-1:0]  count_q;
    logic [STASH_SIZE-1:0] hit_vec;
    logic [STASH_SIZE-1:0] free_sel;

    // fully associative compare against every occupied slot
    for (genvar s = 0; s < STASH_SIZE; s++) begin : g_match
        assign hit_vec[s] = valid_q[s] && (key_q[s] == key_i);
    end

    assign hit_o = |hit_vec;

    // keys are unique, so at most one slot contributes here
    always_comb begin
        hit_data_o = '0;
        for (int s = 0; s < STASH_SIZE; s++) begin
            if (hit_vec[s]) begin
                hit_data_o = hit_data_o | data_q[s];
            end
        end
    end

    // isolates the lowest clear bit of valid_q, zero when all slots are used
    assign free_sel = ~valid_q & (valid_q + 1'b1);

    assign full_o = (count_q == CNT_WIDTH'(STASH_SIZE));

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            count_q <= '0;
        end else if (clk_en_i) begin
            if (insert_i) begin
                valid_q <= valid_q | free_sel;
                count_q <= count_q + 1'b1;
            end else if (remove_i) begin
                valid_q <= valid_q & ~hit_vec;
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en_i && insert_i) begin
            for (int s = 0; s < STASH_SIZE; s++) begin
                if (free_sel[s]) begin
                    key_q[s]  <= key_i;
                    data_q[s] <= data_i;
                end
            end
        end
    end

    // placement only inserts while full_o is low
    a_count_bound: assert property (
        @(posedge clk) disable iff (reset) count_q <= CNT_WIDTH'(STASH_SIZE)
    ) else $error("overflow_stash: occupancy above capacity");

endmodule

`default_nettype wire

// File: logic/placement_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module placement_ctrl import cuckoo_pkg::*; #(
    parameter int NUM_TABLES  = 3,
    parameter int BUCKET_SIZE = 2
) (
    input  hash_req_t                                    req_i,
    input  logic                                         clk_en_i,
    input  entry_t [NUM_TABLES-1:0][BUCKET_SIZE-1:0]     rows_i,
    input  logic                                         stash_hit_i,
    input  logic                                         stash_full_i,
    output logic [NUM_TABLES-1:0][BUCKET_SIZE-1:0]       match_o,
    output logic [NUM_TABLES-1:0][BUCKET_SIZE-1:0]       slot_o,
    output logic [NUM_TABLES-1:0]                        write_o,
    output logic [NUM_TABLES-1:0]                        clear_o,
    output entry_t                                       entry_o,
    output logic                                         stash_insert_o,
    output logic                                         stash_remove_o,
    output outcome_t                                     outcome_o
);

    op_e                                  op;
    logic [NUM_TABLES-1:0][BUCKET_SIZE-1:0] match;
    logic [NUM_TABLES-1:0][BUCKET_SIZE-1:0] used;
    logic [NUM_TABLES-1:0][BUCKET_SIZE-1:0] target;
    logic                                 key_found;
    logic                                 table_free;
    logic                                 place_table;
    logic                                 place_stash;
    logic                                 is_write;
    logic                                 is_delete;

    assign op = clk_en_i ? req_i.op : OP_NOP; // a stalled cycle behaves like a nop

    for (genvar t = 0; t < NUM_TABLES; t++) begin : g_table
        for (genvar b = 0; b < BUCKET_SIZE; b++) begin : g_bucket
            assign used[t][b]  = rows_i[t][b].valid;
            assign match[t][b] = rows_i[t][b].valid && (rows_i[t][b].key == req_i.key);
        end
    end

    assign key_found = (|match) || stash_hit_i;

    // table 0 sits in the low bits, so the lowest clear bit is the first-fit slot
    assign target     = ~used & (used + 1'b1);
    assign table_free = |target;

    assign is_write  = (op == OP_WRITE);
    assign is_delete = (op == OP_DELETE);

    assign place_table = is_write && !key_found && table_free;
    assign place_stash = is_write && !key_found && !table_free && !stash_full_i; // spill only when every row is full

    for (genvar t = 0; t < NUM_TABLES; t++) begin : g_cmd
        assign write_o[t] = place_table && (|target[t]);
        assign clear_o[t] = is_delete && (|match[t]);
        assign slot_o[t]  = is_delete ? match[t] : target[t];
    end

    assign entry_o.valid = 1'b1;
    assign entry_o.key   = req_i.key;
    assign entry_o.data  = req_i.data;

    assign stash_insert_o = place_stash;
    assign stash_remove_o = is_delete && stash_hit_i;

    assign match_o = match;

    assign outcome_o.op         = op;
    assign outcome_o.key_found  = key_found;
    assign outcome_o.placed     = place_table || place_stash;
    assign outcome_o.from_stash = stash_hit_i;

    // a key lives in one place only, across all tables and the stash
    always_comb begin
        if (op != OP_NOP) begin
            a_single_match: assert final ($countones({match, stash_hit_i}) <= 1)
                else $error("placement_ctrl: key stored more than once");
        end
    end

endmodule

`default_nettype wire

// File: logic/response_builder.sv
`timescale 1ns/1ps
`default_nettype none

module response_builder import cuckoo_pkg::*; #(
    parameter int NUM_TABLES  = 3,
    parameter int BUCKET_SIZE = 2
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     clk_en_i,
    input  outcome_t                                 outcome_i,
    input  logic [NUM_TABLES-1:0][BUCKET_SIZE-1:0]   match_i,
    input  entry_t [NUM_TABLES-1:0][BUCKET_SIZE-1:0] rows_i,
    input  logic [DATA_WIDTH-1:0]                    stash_data_i,
    output hash_rsp_t                                rsp_o
);

    logic [DATA_WIDTH-1:0] table_data;
    hash_rsp_t             rsp_d;
    hash_rsp_t             rsp_q;

    // match_i is one-hot or zero, so an OR of the gated data is enough
    always_comb begin
        table_data = '0;
        for (int t = 0; t < NUM_TABLES; t++) begin
            for (int b = 0; b < BUCKET_SIZE; b++) begin
                if (match_i[t][b]) begin
                    table_data = table_data | rows_i[t][b].data;
                end
            end
        end
    end

    always_comb begin
        rsp_d.valid     = (outcome_i.op != OP_NOP);
        rsp_d.read_data = outcome_i.from_stash ? stash_data_i : table_data; // zero when nothing matched
        rsp_d.no_element_found    = (outcome_i.op == OP_READ) && !outcome_i.key_found;
        rsp_d.no_deletion_target  = (outcome_i.op == OP_DELETE) && !outcome_i.key_found;
        rsp_d.key_already_present = (outcome_i.op == OP_WRITE) && outcome_i.key_found;
        rsp_d.no_write_space      = (outcome_i.op == OP_WRITE) && !outcome_i.key_found
                                    && !outcome_i.placed;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_q <= '0;
        end else if (clk_en_i) begin
            rsp_q <= rsp_d;
        end else begin
            rsp_q.valid <= 1'b0; // payload holds, only the strobe drops
        end
    end

    assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// File: test/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker import cuckoo_pkg::*; #(
    parameter int NUM_TABLES  = 3,
    parameter int BUCKET_SIZE = 2,
    parameter int INDEX_WIDTH = 2,
    parameter int STASH_SIZE  = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_en_i,
    input  hash_req_t req_i,
    input  hash_rsp_t rsp_i,
    output int        checks_o,
    output int        mismatches_o,
    output int        refused_o
);

    localparam int ROWS = 1 << INDEX_WIDTH;

    entry_t    tbl [NUM_TABLES][ROWS][BUCKET_SIZE];
    entry_t    stash [STASH_SIZE];
    int        stash_count;
    hash_rsp_t expected;
    hash_req_t last_req;
    logic      armed = 1'b0;
    int        checks = 0;
    int        mismatches = 0;
    int        refused = 0;

    assign checks_o     = checks;
    assign mismatches_o = mismatches;
    assign refused_o    = refused;

    // salted key bits are folded modulo the index width, which is the slice xor
    function automatic logic [INDEX_WIDTH-1:0] row_of(input logic [KEY_WIDTH-1:0] key,
                                                      input int t);
        logic [KEY_WIDTH-1:0]   salted;
        logic [INDEX_WIDTH-1:0] idx;
        salted = key ^ TABLE_SALT[t];
        idx = '0;
        for (int i = 0; i < KEY_WIDTH; i++) begin
            idx[i % INDEX_WIDTH] = idx[i % INDEX_WIDTH] ^ salted[i];
        end
        return idx;
    endfunction

    // expected response of one sampled request, and the model update it causes
    function automatic hash_rsp_t apply_request(input hash_req_t req);
        hash_rsp_t              rsp;
        logic                   found;
        logic                   placed;
        logic [INDEX_WIDTH-1:0] idx;
        rsp = '0;
        rsp.valid = 1'b1;
        found = 1'b0;
        for (int t = 0; t < NUM_TABLES; t++) begin
            idx = row_of(req.key, t);
            for (int b = 0; b < BUCKET_SIZE; b++) begin
                if (tbl[t][idx][b].valid && tbl[t][idx][b].key == req.key) begin
                    found = 1'b1;
                    rsp.read_data = tbl[t][idx][b].data; // every op returns the data it found
                    if (req.op == OP_DELETE) begin
                        tbl[t][idx][b].valid = 1'b0;
                    end
                end
            end
        end
        for (int s = 0; s < STASH_SIZE; s++) begin
            if (stash[s].valid && stash[s].key == req.key) begin
                found = 1'b1;
                rsp.read_data = stash[s].data;
                if (req.op == OP_DELETE) begin
                    stash[s].valid = 1'b0;
                    stash_count--;
                end
            end
        end
        case (req.op)
            OP_READ:   rsp.no_element_found = !found;
            OP_DELETE: rsp.no_deletion_target = !found;
            default: begin
                rsp.key_already_present = found;
                placed = found;
                for (int t = 0; t < NUM_TABLES; t++) begin
                    idx = row_of(req.key, t);
                    for (int b = 0; b < BUCKET_SIZE; b++) begin
                        if (!placed && !tbl[t][idx][b].valid) begin
                            tbl[t][idx][b] = {1'b1, req.key, req.data}; // first table, lowest bucket
                            placed = 1'b1;
                        end
                    end
                end
                if (!placed && stash_count < STASH_SIZE) begin
                    for (int s = 0; s < STASH_SIZE; s++) begin
                        if (!placed && !stash[s].valid) begin
                            stash[s] = {1'b1, req.key, req.data};
                            stash_count++;
                            placed = 1'b1;
                        end
                    end
                end
                rsp.no_write_space = !placed;
            end
        endcase
        return rsp;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            for (int t = 0; t < NUM_TABLES; t++) begin
                for (int r = 0; r < ROWS; r++) begin
                    for (int b = 0; b < BUCKET_SIZE; b++) begin
                        tbl[t][r][b] = '0;
                    end
                end
            end
            for (int s = 0; s < STASH_SIZE; s++) begin
                stash[s] = '0;
            end
            stash_count = 0;
            expected = '0;
        end else if (clk_en_i && req_i.op != OP_NOP) begin
            expected = apply_request(req_i);
        end else begin
            expected = '0; // stalled or idle cycle leaves the model alone
        end
        last_req = req_i;
        armed = 1'b1;
    end

    // the response of the last edge is stable by the falling edge
    always @(negedge clk) begin
        if (armed) begin
            checks++;
            if (expected.valid) begin
                if (rsp_i !== expected) begin
                    mismatches++;
                    $display("MISMATCH at %0t: op %0d key %h, response %h, model expects %h",
                             $time, last_req.op, last_req.key, rsp_i, expected);
                end else if (expected.no_write_space) begin
                    refused++;
                end
            end else if (rsp_i.valid !== 1'b0) begin
                mismatches++;
                $display("MISMATCH at %0t: valid response without a sampled request", $time);
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_cuckoo_hash.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cuckoo_hash import cuckoo_pkg::*; ();

    localparam int NUM_TABLES    = 3;
    localparam int BUCKET_SIZE   = 2;
    localparam int INDEX_WIDTH   = 2;
    localparam int STASH_SIZE    = 4;
    localparam int POOL_SIZE     = 40;
    localparam int RSP_TIMEOUT   = 20; // cycles
    localparam int RANDOM_CYCLES = 600;
    localparam int FILL_KEYS     = 12;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 clk_en;
    hash_req_t            req;
    hash_rsp_t            rsp;
    int                   checks;
    int                   mismatches;
    int                   refused;
    int                   failures = 0; // timeouts and scenarios that never happened
    int                   refused_before;
    logic [KEY_WIDTH-1:0] pool [POOL_SIZE];

    always #10 clk = ~clk;

    cuckoo_hash_top #(
        .NUM_TABLES (NUM_TABLES),
        .BUCKET_SIZE(BUCKET_SIZE),
        .INDEX_WIDTH(INDEX_WIDTH),
        .STASH_SIZE (STASH_SIZE)
    ) i_dut (
        .clk     (clk),
        .reset   (reset),
        .clk_en_i(clk_en),
        .req_i   (req),
        .rsp_o   (rsp)
    );

    tb_checker #(
        .NUM_TABLES (NUM_TABLES),
        .BUCKET_SIZE(BUCKET_SIZE),
        .INDEX_WIDTH(INDEX_WIDTH),
        .STASH_SIZE (STASH_SIZE)
    ) i_checker (
        .clk         (clk),
        .reset       (reset),
        .clk_en_i    (clk_en),
        .req_i       (req),
        .rsp_i       (rsp),
        .checks_o    (checks),
        .mismatches_o(mismatches),
        .refused_o   (refused)
    );

    // equal bytes cancel in the fold, so these keys share one row in every table
    function automatic logic [KEY_WIDTH-1:0] collide_key(input int j);
        logic [7:0] b;
        b = j[7:0];
        return {b, b};
    endfunction

    function automatic op_e pick_op(input int unsigned r);
        case (r % 8)
            0:       return OP_NOP;
            1, 2:    return OP_READ;
            3, 4, 5: return OP_WRITE;
            default: return OP_DELETE;
        endcase
    endfunction

    task automatic drive(input logic en, input op_e op, input logic [KEY_WIDTH-1:0] key,
                         input logic [DATA_WIDTH-1:0] data);
        @(negedge clk);
        clk_en = en;
        req.op = op;
        req.key = key;
        req.data = data;
    endtask

    // one request, then idle until its response shows up
    task automatic transact(input op_e op, input logic [KEY_WIDTH-1:0] key,
                            input logic [DATA_WIDTH-1:0] data);
        int waited;
        drive(1'b1, op, key, data);
        drive(1'b1, OP_NOP, key, data);
        waited = 0;
        while (!rsp.valid && waited < RSP_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!rsp.valid) begin
            failures++;
            $display("timeout: no response to %s of key %h", op.name(), key);
        end
    endtask

    task automatic log_test(input string name, input int errors_before);
        @(posedge clk); // the checker updates its counts at the falling edge
        $display("test %s finished with %0d mismatches", name, mismatches - errors_before);
    endtask

    task automatic run_random();
        int unsigned pick;
        logic        en;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            pick = $urandom % POOL_SIZE;
            en = (($urandom % 8) != 0);
            drive(en, pick_op($urandom), pool[pick], $urandom);
        end
        drive(1'b1, OP_NOP, '0, '0);
        drive(1'b1, OP_NOP, '0, '0);
    endtask

    initial begin
        int errs;
        void'($urandom(32'h10ea));
        reset = 1'b1;
        clk_en = 1'b0;
        req = '0;
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = (i < FILL_KEYS) ? collide_key(i + 1) : KEY_WIDTH'($urandom);
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(posedge clk);

        errs = mismatches;
        transact(OP_READ, 16'h0000, '0);
        transact(OP_READ, 16'hbeef, '0);
        log_test("reset_read", errs);

        errs = mismatches;
        transact(OP_WRITE, 16'h0001, 32'hcafe_0001);
        transact(OP_READ, 16'h0001, '0);
        transact(OP_WRITE, 16'h0001, 32'h1111_2222); // already present, data must stay
        transact(OP_READ, 16'h0001, '0);
        log_test("write_read", errs);

        errs = mismatches;
        refused_before = refused;
        for (int j = 1; j <= FILL_KEYS; j++) begin
            transact(OP_WRITE, collide_key(j), 32'h3000_0000 + j);
        end
        for (int j = 1; j <= FILL_KEYS; j++) begin
            transact(OP_READ, collide_key(j), '0);
        end
        if (refused - refused_before != FILL_KEYS - NUM_TABLES * BUCKET_SIZE - STASH_SIZE) begin
            failures++;
            $display("fill: writes past a full row and full stash were not refused as expected");
        end
        log_test("fill_spill", errs);

        errs = mismatches;
        transact(OP_DELETE, collide_key(1), '0); // table resident
        transact(OP_DELETE, collide_key(8), '0); // stash resident
        transact(OP_READ, collide_key(1), '0);
        transact(OP_READ, collide_key(8), '0);
        transact(OP_DELETE, collide_key(8), '0);
        transact(OP_DELETE, 16'hdead, '0);
        transact(OP_WRITE, collide_key(11), 32'h4000_0011);
        transact(OP_WRITE, collide_key(12), 32'h4000_0012);
        transact(OP_READ, collide_key(11), '0);
        transact(OP_READ, collide_key(12), '0);
        log_test("delete", errs);

        errs = mismatches;
        repeat (3) drive(1'b0, OP_WRITE, 16'h4242, 32'h5555_aaaa);
        drive(1'b1, OP_NOP, 16'h4242, 32'h5555_aaaa);
        transact(OP_READ, 16'h4242, '0);
        log_test("idle_cycles", errs);

        errs = mismatches;
        run_random();
        log_test("random_mix", errs);

        $display("summary: %0d checks, %0d mismatches, %0d other failures",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0 && checks > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
